// File: radio_ctrl.f
common/spi_proto_pkg.sv
common/rf_ctrl_pkg.sv
spi_if/spi_if.sv
rtl/sys_ctrl.sv
rtl/io_ctrl.sv
rtl/radio_ctrl_top.sv
verification/radio_ctrl_assert.sv
verification/tb_radio_ctrl.sv

// File: build_sim.sh
#!/bin/sh
# Compile and run the radio control testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module tb_radio_ctrl \
   -f radio_ctrl.f \
   -o sim_radio_ctrl

./obj_dir/sim_radio_ctrl | tee sim.log

if grep -q "Finished with no errors" sim.log; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed, see sim.log"
   exit 1
fi

// File: verification/tb_radio_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_radio_ctrl;

   import spi_proto_pkg::*;
   import rf_ctrl_pkg::*;

   localparam spi_byte_t TB_VERSION = 8'h37;   // Not the package default
   localparam int        HALF_SCK   = 10;      // SCK half period in clocks
   // About 45 transfers of 16 bits at 20 clocks each plus gaps, near 170 us
   localparam time       WATCHDOG_NS = 200_000;

   logic       i_glob_clock;
   logic       i_rst_n;
   logic       i_mosi;
   logic       i_sck;
   logic       i_ss;
   logic       o_miso;
   logic       o_miso_oe;
   logic       i_button;
   logic [3:0] i_config;
   logic       o_ldo_2v8_en;
   logic       o_led0;
   logic       o_led1;
   logic       o_mixer_fm;
   logic       o_mixer_en;
   logic       o_rx_h_tx_l;
   logic       o_rx_h_tx_l_b;
   logic       o_tr_vc1;
   logic       o_tr_vc1_b;
   logic       o_tr_vc2;
   logic       o_shdn_rx_lna;
   logic       o_shdn_tx_lna;

   int          error_count;
   int          check_count;
   int unsigned assert_fails;
   logic [31:0] lfsr_state;

   radio_ctrl_top #(
      .VERSION (TB_VERSION)
   ) radio_ctrl_top_inst (
      .i_glob_clock  (i_glob_clock),
      .i_rst_n       (i_rst_n),
      .i_mosi        (i_mosi),
      .i_sck         (i_sck),
      .i_ss          (i_ss),
      .o_miso        (o_miso),
      .o_miso_oe     (o_miso_oe),
      .i_button      (i_button),
      .i_config      (i_config),
      .o_ldo_2v8_en  (o_ldo_2v8_en),
      .o_led0        (o_led0),
      .o_led1        (o_led1),
      .o_mixer_fm    (o_mixer_fm),
      .o_mixer_en    (o_mixer_en),
      .o_rx_h_tx_l   (o_rx_h_tx_l),
      .o_rx_h_tx_l_b (o_rx_h_tx_l_b),
      .o_tr_vc1      (o_tr_vc1),
      .o_tr_vc1_b    (o_tr_vc1_b),
      .o_tr_vc2      (o_tr_vc2),
      .o_shdn_rx_lna (o_shdn_rx_lna),
      .o_shdn_tx_lna (o_shdn_tx_lna)
   );

   bind radio_ctrl_top radio_ctrl_assert radio_ctrl_assert_inst (
      .i_glob_clock  (i_glob_clock),
      .i_rst_n       (i_rst_n),
      .i_ss          (i_ss),
      .i_miso_oe     (o_miso_oe),
      .i_fetch       (w_fetch),
      .i_load        (w_load),
      .i_cs          (w_cs),
      .i_rx_h_tx_l   (o_rx_h_tx_l),
      .i_rx_h_tx_l_b (o_rx_h_tx_l_b),
      .i_tr_vc1      (o_tr_vc1),
      .i_tr_vc1_b    (o_tr_vc1_b)
   );

   initial i_glob_clock = 1'b0;
   always #5 i_glob_clock = ~i_glob_clock;      // 100 MHz

   // ==================================================
   // Stimulus helpers
   // ==================================================
   task automatic tick(input int n);
      repeat (n) @(posedge i_glob_clock);
      #1;                                       // Drive just after the edge
   endtask

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32+x^22+x^2+x+1
   endfunction

   task automatic rand_byte(output spi_byte_t b);
      for (int i = 0; i < 8; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         b = {b[6:0], lfsr_state[0]};
      end
   endtask

   // Mode 0 frame, MOSI set while SCK low, MISO sampled before each rise
   task automatic spi_xfer(input spi_byte_t cmd, input spi_byte_t data,
                           input int n_bits, output spi_byte_t rx);
      rx   = '0;
      i_ss = 1'b0;
      tick(HALF_SCK);
      check_byte({7'b0, o_miso_oe}, 8'h01, "MISO enable while selected");
      for (int i = 0; i < n_bits; i++) begin
         i_mosi = (i < 8) ? cmd[7-i] : data[15-i];
         tick(HALF_SCK);
         if (i >= 8)
            rx[15-i] = o_miso;
         i_sck = 1'b1;
         tick(HALF_SCK);
         i_sck = 1'b0;
      end
      tick(HALF_SCK);
      i_ss   = 1'b1;                            // End or abort
      i_mosi = 1'b0;
      tick(2 * HALF_SCK);
   endtask

   task automatic spi_write(input blk_sel_t blk, input ioc_t ioc, input spi_byte_t data);
      spi_byte_t unused;
      spi_xfer({1'b1, blk, ioc}, data, 16, unused);
   endtask

   task automatic spi_read(input blk_sel_t blk, input ioc_t ioc, output spi_byte_t data);
      spi_xfer({1'b0, blk, ioc}, 8'h00, 16, data);
   endtask

   // ==================================================
   // Compare tasks
   // ==================================================
   task automatic check_byte(input spi_byte_t got, input spi_byte_t exp, input string what);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("FAIL @%0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_rf_pins(input rf_mode_t mode);
      logic [5:0] exp;                          // shdn_rx shdn_tx mix_en rx_h vc1 vc2
      logic [5:0] got;
      check_count++;
      case (mode)
         RF_RX_09: exp = 6'b011110;
         RF_RX_24: exp = 6'b011101;
         RF_TX_09: exp = 6'b101010;
         RF_TX_24: exp = 6'b101001;
         default:  exp = 6'b110100;             // RF_OFF
      endcase
      got = {o_shdn_rx_lna, o_shdn_tx_lna, o_mixer_en, o_rx_h_tx_l, o_tr_vc1, o_tr_vc2};
      if (got !== exp || o_rx_h_tx_l_b !== ~exp[2] || o_tr_vc1_b !== ~exp[1]) begin
         error_count++;
         $display("FAIL @%0t ns: RF pins %b for mode %0d, expected %b", $time, got, mode, exp);
      end
   endtask

   // ==================================================
   // Directed tests
   // ==================================================
   task automatic reset_defaults();
      spi_byte_t rd;
      check_rf_pins(RF_OFF);
      check_byte({4'b0, o_mixer_fm, o_ldo_2v8_en, o_led1, o_led0}, 8'h00, "digital outputs");
      spi_read(BLK_SYS, SYS_IOC_VERSION, rd);
      check_byte(rd, TB_VERSION, "version");
   endtask

   task automatic scratch_lfsr();
      spi_byte_t wr;
      spi_byte_t rd;
      repeat (8) begin
         rand_byte(wr);
         spi_write(BLK_SYS, SYS_IOC_SCRATCH, wr);
         spi_read(BLK_SYS, SYS_IOC_SCRATCH, rd);
         check_byte(rd, wr, "scratch readback");
      end
   endtask

   task automatic rf_mode_sweep();
      spi_byte_t rd;
      rf_mode_t  mode;
      for (int m = 0; m < 5; m++) begin
         mode = rf_mode_t'(3'(m));
         spi_write(BLK_IO, IO_IOC_RF_MODE, {5'b0, mode});
         check_rf_pins(mode);
         spi_read(BLK_IO, IO_IOC_RF_MODE, rd);
         check_byte(rd, {5'b0, mode}, "RF mode readback");
      end
      spi_write(BLK_IO, IO_IOC_RF_MODE, 8'h07);   // Invalid, mode stays TX 2.4
      spi_write(BLK_IO, IO_IOC_RF_MODE, 8'h05);
      check_rf_pins(RF_TX_24);
      spi_read(BLK_IO, IO_IOC_RF_MODE, rd);
      check_byte(rd, 8'h04, "RF mode after invalid code");
      spi_write(BLK_IO, IO_IOC_RF_MODE, 8'h00);
   endtask

   task automatic digital_io();
      spi_byte_t rd;
      spi_write(BLK_IO, IO_IOC_DIG_OUT, 8'h05);
      check_byte({4'b0, o_mixer_fm, o_ldo_2v8_en, o_led1, o_led0}, 8'h05, "DIG_OUT pins");
      spi_write(BLK_IO, IO_IOC_DIG_OUT, 8'h0A);
      check_byte({4'b0, o_mixer_fm, o_ldo_2v8_en, o_led1, o_led0}, 8'h0A, "DIG_OUT pins");
      i_button = 1'b1;
      i_config = 4'b0110;
      spi_read(BLK_IO, IO_IOC_DIG_IN, rd);
      check_byte(rd, 8'h16, "DIG_IN");            // Button lands in bit 4
      i_button = 1'b0;
      i_config = 4'b1001;
      spi_read(BLK_IO, IO_IOC_DIG_IN, rd);
      check_byte(rd, 8'h09, "DIG_IN");
      spi_write(BLK_IO, IO_IOC_DIG_OUT, 8'h00);
   endtask

   task automatic block_and_status();
      spi_byte_t rd;
      spi_read(BLK_SMI, 5'd0, rd);
      check_byte(rd, 8'h00, "SMI block");
      spi_read(BLK_RSV, 5'd0, rd);
      check_byte(rd, 8'hA5, "reserved block");
      spi_read(BLK_SYS, SYS_IOC_STATUS, rd);
      check_byte(rd, 8'h00, "status before error");
      spi_read(BLK_SYS, 5'd9, rd);                // Undefined register
      spi_read(BLK_SYS, SYS_IOC_STATUS, rd);
      check_byte(rd, 8'h01, "status after bad access");
      spi_write(BLK_SYS, SYS_IOC_STATUS, 8'h01);  // Write 1 clears
      spi_read(BLK_SYS, SYS_IOC_STATUS, rd);
      check_byte(rd, 8'h00, "status after clear");
   endtask

   task automatic aborted_write();
      spi_byte_t rd;
      spi_write(BLK_SYS, SYS_IOC_SCRATCH, 8'h3C);
      spi_xfer({1'b1, BLK_SYS, SYS_IOC_SCRATCH}, 8'hC3, 12, rd);   // SS up after 4 bits
      spi_read(BLK_SYS, SYS_IOC_SCRATCH, rd);
      check_byte(rd, 8'h3C, "scratch after abort");
   endtask

   // ==================================================
   // Main sequence and watchdog
   // ==================================================
   initial begin
      i_rst_n     = 1'b0;
      i_mosi      = 1'b0;
      i_sck       = 1'b0;
      i_ss        = 1'b1;
      i_button    = 1'b0;
      i_config    = 4'b0;
      error_count = 0;
      check_count = 0;
      lfsr_state  = 32'hb907;
      tick(10);                                 // Reset for 10 cycles
      i_rst_n = 1'b1;
      tick(5);
      reset_defaults();
      scratch_lfsr();
      rf_mode_sweep();
      digital_io();
      block_and_status();
      aborted_write();
      assert_fails = radio_ctrl_top_inst.radio_ctrl_assert_inst.fail_count;
      $display("Checks: %0d, errors: %0d, assertion failures: %0d",
               check_count, error_count, assert_fails);
      if (error_count == 0 && assert_fails == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: the tests did not complete within %0t ns", $time);
      $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire

// File: verification/radio_ctrl_assert.sv
`timescale 1ns/1ps
`default_nettype none

module radio_ctrl_assert (
   input logic                   i_glob_clock,
   input logic                   i_rst_n,
   input logic                   i_ss,
   input logic                   i_miso_oe,
   input logic                   i_fetch,
   input logic                   i_load,
   input spi_proto_pkg::blk_cs_t i_cs,
   input logic                   i_rx_h_tx_l,
   input logic                   i_rx_h_tx_l_b,
   input logic                   i_tr_vc1,
   input logic                   i_tr_vc1_b
);

   int unsigned fail_count = 0;          // Failed assertions so far

   // ==================================================
   // Strobes and block select
   // ==================================================
   a_strobe_excl: assert property (@(posedge i_glob_clock) disable iff (!i_rst_n)
      !(i_fetch && i_load))
      else begin
         $error("Fetch and load strobes high in the same cycle");
         fail_count++;
      end

   a_cs_onehot: assert property (@(posedge i_glob_clock) disable iff (!i_rst_n)
      $onehot0(i_cs))
      else begin
         $error("Block select not one-hot or zero: %b", i_cs);
         fail_count++;
      end

   // ==================================================
   // Front-end pin pairs and MISO enable
   // ==================================================
   a_rx_tx_pair: assert property (@(posedge i_glob_clock)
      i_rx_h_tx_l_b == ~i_rx_h_tx_l)
      else begin
         $error("rx_h_tx_l_b is not the inverse of rx_h_tx_l");
         fail_count++;
      end

   a_vc1_pair: assert property (@(posedge i_glob_clock)
      i_tr_vc1_b == ~i_tr_vc1)
      else begin
         $error("tr_vc1_b is not the inverse of tr_vc1");
         fail_count++;
      end

   a_miso_oe: assert property (@(posedge i_glob_clock)
      i_ss |-> !i_miso_oe)              // No drive while deselected
      else begin
         $error("MISO enabled while SS is high");
         fail_count++;
      end

endmodule

`default_nettype wire

// File: rtl/radio_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module radio_ctrl_top #(
   parameter spi_proto_pkg::spi_byte_t VERSION = rf_ctrl_pkg::FW_VERSION
) (
   input  logic       i_glob_clock,
   input  logic       i_rst_n,
   // SPI slave
   input  logic       i_mosi,
   input  logic       i_sck,
   input  logic       i_ss,
   output logic       o_miso,
   output logic       o_miso_oe,
   // Digital I/F
   input  logic       i_button,
   input  logic [3:0] i_config,
   output logic       o_ldo_2v8_en,
   output logic       o_led0,
   output logic       o_led1,
   // RF front-end and mixer
   output logic       o_mixer_fm,
   output logic       o_mixer_en,
   output logic       o_rx_h_tx_l,
   output logic       o_rx_h_tx_l_b,
   output logic       o_tr_vc1,
   output logic       o_tr_vc1_b,
   output logic       o_tr_vc2,
   output logic       o_shdn_rx_lna,
   output logic       o_shdn_tx_lna
);

   import spi_proto_pkg::*;

   ioc_t      w_ioc;
   spi_byte_t w_rx_data;
   spi_byte_t r_tx_data;       // Registered readback into the SPI shifter
   spi_byte_t w_tx_data_sys;
   spi_byte_t w_tx_data_io;
   blk_cs_t   w_cs;
   logic      w_fetch;
   logic      w_load;
   logic      w_miso;

   // ==================================================
   // Instances
   // ==================================================
   spi_if spi_if_inst (
      .i_glob_clock (i_glob_clock),
      .i_rst_n      (i_rst_n),
      .i_spi_sck    (i_sck),
      .i_spi_mosi   (i_mosi),
      .i_spi_cs_b   (i_ss),
      .o_spi_miso   (w_miso),
      .i_data_out   (r_tx_data),
      .o_ioc        (w_ioc),
      .o_data_in    (w_rx_data),
      .o_cs         (w_cs),
      .o_fetch_cmd  (w_fetch),
      .o_load_cmd   (w_load)
   );

   sys_ctrl #(
      .VERSION (VERSION)
   ) sys_ctrl_inst (
      .i_glob_clock (i_glob_clock),
      .i_rst_n      (i_rst_n),
      .i_ioc        (w_ioc),
      .i_data_in    (w_rx_data),
      .i_cs         (w_cs[BLK_SYS]),
      .i_fetch_cmd  (w_fetch),
      .i_load_cmd   (w_load),
      .o_data_out   (w_tx_data_sys)
   );

   io_ctrl io_ctrl_inst (
      .i_glob_clock  (i_glob_clock),
      .i_rst_n       (i_rst_n),
      .i_ioc         (w_ioc),
      .i_data_in     (w_rx_data),
      .i_cs          (w_cs[BLK_IO]),
      .i_fetch_cmd   (w_fetch),
      .i_load_cmd    (w_load),
      .o_data_out    (w_tx_data_io),
      .i_button      (i_button),
      .i_config      (i_config),
      .o_ldo_2v8_en  (o_ldo_2v8_en),
      .o_led0        (o_led0),
      .o_led1        (o_led1),
      .o_mixer_fm    (o_mixer_fm),
      .o_mixer_en    (o_mixer_en),
      .o_rx_h_tx_l   (o_rx_h_tx_l),
      .o_rx_h_tx_l_b (o_rx_h_tx_l_b),
      .o_tr_vc1      (o_tr_vc1),
      .o_tr_vc1_b    (o_tr_vc1_b),
      .o_tr_vc2      (o_tr_vc2),
      .o_shdn_rx_lna (o_shdn_rx_lna),
      .o_shdn_tx_lna (o_shdn_tx_lna)
   );

   // ==================================================
   // Readback multiplexer
   // ==================================================
   always_ff @(posedge i_glob_clock or negedge i_rst_n) begin
      if (!i_rst_n) begin
         r_tx_data <= '0;
      end else begin
         case (w_cs)
            blk_cs_t'(1) << BLK_SYS: r_tx_data <= w_tx_data_sys;
            blk_cs_t'(1) << BLK_IO:  r_tx_data <= w_tx_data_io;
            blk_cs_t'(1) << BLK_SMI: r_tx_data <= 8'h00;  // No SMI registers here
            blk_cs_t'(1) << BLK_RSV: r_tx_data <= BLK_RESERVED_DATA;
            default:                 r_tx_data <= 8'h00;  // Nothing selected
         endcase
      end
   end

   // MISO only driven while the host selects us
   assign o_miso    = i_ss ? 1'b0 : w_miso;
   assign o_miso_oe = ~i_ss;

endmodule

`default_nettype wire

// File: rtl/io_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module io_ctrl (
   input  logic                     i_glob_clock,
   input  logic                     i_rst_n,
   input  spi_proto_pkg::ioc_t      i_ioc,
   input  spi_proto_pkg::spi_byte_t i_data_in,
   input  logic                     i_cs,
   input  logic                     i_fetch_cmd,
   input  logic                     i_load_cmd,
   output spi_proto_pkg::spi_byte_t o_data_out,
   // Board digital pins
   input  logic                     i_button,
   input  logic [3:0]               i_config,
   output logic                     o_ldo_2v8_en,
   output logic                     o_led0,
   output logic                     o_led1,
   // RF front-end and mixer
   output logic                     o_mixer_fm,
   output logic                     o_mixer_en,
   output logic                     o_rx_h_tx_l,
   output logic                     o_rx_h_tx_l_b,
   output logic                     o_tr_vc1,
   output logic                     o_tr_vc1_b,
   output logic                     o_tr_vc2,
   output logic                     o_shdn_rx_lna,
   output logic                     o_shdn_tx_lna
);

   import spi_proto_pkg::*;
   import rf_ctrl_pkg::*;

   rf_mode_t                         r_rf_mode;
   logic [3:0]                       r_dig_out;
   logic [SCK_SYNC_STAGES-1:0][4:0]  r_din_sync;  // {button, config}
   logic [4:0]                       w_dig_in;

   // ==================================================
   // Button and config synchronizer
   // ==================================================
   always_ff @(posedge i_glob_clock or negedge i_rst_n) begin
      if (!i_rst_n)
         r_din_sync <= '0;
      else
         r_din_sync <= {r_din_sync[SCK_SYNC_STAGES-2:0], {i_button, i_config}};
   end

   assign w_dig_in = r_din_sync[SCK_SYNC_STAGES-1];   // Button in bit 4

   // ==================================================
   // Register access
   // ==================================================
   always_ff @(posedge i_glob_clock or negedge i_rst_n) begin
      if (!i_rst_n) begin
         r_rf_mode  <= RF_OFF;
         r_dig_out  <= '0;
         o_data_out <= '0;
      end else if (i_cs) begin
         if (i_fetch_cmd) begin
            case (i_ioc)
               IO_IOC_RF_MODE: o_data_out <= {5'b0, r_rf_mode};
               IO_IOC_DIG_OUT: o_data_out <= {4'b0, r_dig_out};
               IO_IOC_DIG_IN:  o_data_out <= {3'b0, w_dig_in};
               default:        o_data_out <= '0;
            endcase
         end
         if (i_load_cmd) begin
            case (i_ioc)
               IO_IOC_RF_MODE: begin
                  // Codes above RF_TX_24 keep the current mode
                  if (i_data_in <= spi_byte_t'(RF_TX_24))
                     r_rf_mode <= rf_mode_t'(i_data_in[2:0]);
               end
               IO_IOC_DIG_OUT: r_dig_out <= i_data_in[3:0];
               default: ;                               // DIG_IN is read only
            endcase
         end
      end
   end

   // ==================================================
   // Front-end decode
   // ==================================================
   always_comb begin
      // RF_OFF values, both LNAs in shutdown
      o_shdn_rx_lna = 1'b1;
      o_shdn_tx_lna = 1'b1;
      o_mixer_en    = 1'b0;
      o_rx_h_tx_l   = 1'b1;
      o_tr_vc1      = 1'b0;
      o_tr_vc2      = 1'b0;
      case (r_rf_mode)
         RF_RX_09, RF_RX_24: begin
            o_shdn_rx_lna = 1'b0;
            o_mixer_en    = 1'b1;
            o_tr_vc1      = (r_rf_mode == RF_RX_09);    // Sub-GHz path
            o_tr_vc2      = (r_rf_mode == RF_RX_24);
         end
         RF_TX_09, RF_TX_24: begin
            o_shdn_tx_lna = 1'b0;
            o_mixer_en    = 1'b1;
            o_rx_h_tx_l   = 1'b0;
            o_tr_vc1      = (r_rf_mode == RF_TX_09);
            o_tr_vc2      = (r_rf_mode == RF_TX_24);    // 2.4 GHz path
         end
         default: ;
      endcase
   end

   assign o_rx_h_tx_l_b = ~o_rx_h_tx_l;   // Complementary switch drive
   assign o_tr_vc1_b    = ~o_tr_vc1;

   assign o_led0       = r_dig_out[DOUT_LED0];
   assign o_led1       = r_dig_out[DOUT_LED1];
   assign o_ldo_2v8_en = r_dig_out[DOUT_LDO_2V8];
   assign o_mixer_fm   = r_dig_out[DOUT_MIXER_FM];

endmodule

`default_nettype wire

// File: rtl/sys_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module sys_ctrl #(
   parameter spi_proto_pkg::spi_byte_t VERSION = rf_ctrl_pkg::FW_VERSION
) (
   input  logic                     i_glob_clock,
   input  logic                     i_rst_n,
   input  spi_proto_pkg::ioc_t      i_ioc,
   input  spi_proto_pkg::spi_byte_t i_data_in,
   input  logic                     i_cs,
   input  logic                     i_fetch_cmd,
   input  logic                     i_load_cmd,
   output spi_proto_pkg::spi_byte_t o_data_out
);

   import spi_proto_pkg::*;
   import rf_ctrl_pkg::*;

   spi_byte_t r_scratch;
   logic      r_err;        // Sticky access error, status bit 0

   always_ff @(posedge i_glob_clock or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_data_out <= '0;
         r_scratch  <= '0;
         r_err      <= 1'b0;
      end else if (i_cs) begin
         if (i_fetch_cmd) begin
            case (i_ioc)
               SYS_IOC_VERSION: o_data_out <= VERSION;
               SYS_IOC_SCRATCH: o_data_out <= r_scratch;
               SYS_IOC_STATUS:  o_data_out <= {7'b0, r_err};
               default: begin
                  o_data_out <= '0;     // Undefined register
                  r_err      <= 1'b1;
               end
            endcase
         end
         if (i_load_cmd) begin
            case (i_ioc)
               SYS_IOC_VERSION: ;                        // Read only
               SYS_IOC_SCRATCH: r_scratch <= i_data_in;
               SYS_IOC_STATUS: begin
                  if (i_data_in[0])
                     r_err <= 1'b0;                      // Write 1 to clear
               end
               default: r_err <= 1'b1;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// File: spi_if/spi_if.sv
`timescale 1ns/1ps
`default_nettype none

module spi_if (
   input  logic                   i_glob_clock,
   input  logic                   i_rst_n,
   // SPI pins, mode 0
   input  logic                   i_spi_sck,
   input  logic                   i_spi_mosi,
   input  logic                   i_spi_cs_b,
   output logic                   o_spi_miso,
   // Register block side
   input  spi_proto_pkg::spi_byte_t i_data_out,
   output spi_proto_pkg::ioc_t      o_ioc,
   output spi_proto_pkg::spi_byte_t o_data_in,
   output spi_proto_pkg::blk_cs_t   o_cs,
   output logic                   o_fetch_cmd,
   output logic                   o_load_cmd
);

   import spi_proto_pkg::*;

   typedef enum logic [1:0] {
      IDLE,                               // SS high
      CMD,                                // Receiving command byte
      DATA,                               // Receiving or sending data byte
      DONE                                // Wait for SS to rise
   } spi_state_t;

   spi_state_t                   r_state;
   logic [SCK_SYNC_STAGES:0]     r_sck_sync;   // One extra stage for edge detect
   logic [SCK_SYNC_STAGES-1:0]   r_ss_sync;
   logic [SCK_SYNC_STAGES-1:0]   r_mosi_sync;
   logic                         w_sck_rise;
   logic                         w_sck_fall;
   logic                         w_ss_active;
   logic                         w_mosi;
   logic [2:0]                   r_bit_cnt;
   logic [6:0]                   r_rx_shift;
   spi_byte_t                    w_rx_byte;
   spi_byte_t                    r_tx_shift;
   blk_sel_t                     w_blk_sel;
   logic                         r_cmd_write;
   logic                         r_tx_pending; // Readback not yet in shifter

   // ==================================================
   // Input synchronizers and edge detect
   // ==================================================
   always_ff @(posedge i_glob_clock or negedge i_rst_n) begin
      if (!i_rst_n) begin
         r_sck_sync  <= '0;
         r_ss_sync   <= '1;                // Deselected
         r_mosi_sync <= '0;
      end else begin
         r_sck_sync  <= {r_sck_sync[SCK_SYNC_STAGES-1:0], i_spi_sck};
         r_ss_sync   <= {r_ss_sync[SCK_SYNC_STAGES-2:0], i_spi_cs_b};
         r_mosi_sync <= {r_mosi_sync[SCK_SYNC_STAGES-2:0], i_spi_mosi};
      end
   end

   assign w_sck_rise  = r_sck_sync[SCK_SYNC_STAGES-1] & ~r_sck_sync[SCK_SYNC_STAGES];
   assign w_sck_fall  = ~r_sck_sync[SCK_SYNC_STAGES-1] & r_sck_sync[SCK_SYNC_STAGES];
   assign w_ss_active = ~r_ss_sync[SCK_SYNC_STAGES-1];
   assign w_mosi      = r_mosi_sync[SCK_SYNC_STAGES-1];

   // Byte including the bit sampled on this edge
   assign w_rx_byte = {r_rx_shift, w_mosi};
   assign w_blk_sel = w_rx_byte[CMD_BLK_MSB:CMD_BLK_LSB];

   // ==================================================
   // Transaction FSM
   // ==================================================
   always_ff @(posedge i_glob_clock or negedge i_rst_n) begin
      if (!i_rst_n) begin
         r_state      <= IDLE;
         r_bit_cnt    <= '0;
         r_rx_shift   <= '0;
         r_tx_shift   <= '0;
         r_cmd_write  <= 1'b0;
         r_tx_pending <= 1'b0;
         o_ioc        <= '0;
         o_data_in    <= '0;
         o_cs         <= '0;
         o_fetch_cmd  <= 1'b0;
         o_load_cmd   <= 1'b0;
      end else begin
         o_fetch_cmd <= 1'b0;              // Strobes last one cycle
         o_load_cmd  <= 1'b0;
         if (!w_ss_active) begin
            // SS high aborts whatever is in flight
            r_state      <= IDLE;
            r_bit_cnt    <= '0;
            r_tx_shift   <= '0;
            r_tx_pending <= 1'b0;
            o_cs         <= '0;
         end else begin
            case (r_state)
               IDLE: r_state <= CMD;
               CMD: begin
                  if (w_sck_rise) begin
                     r_rx_shift <= w_rx_byte[6:0];
                     r_bit_cnt  <= r_bit_cnt + 3'd1;
                     if (r_bit_cnt == 3'd7) begin
                        // Full command byte, decode it
                        r_cmd_write  <= w_rx_byte[CMD_WR_BIT];
                        o_ioc        <= w_rx_byte[CMD_IOC_MSB:0];
                        o_cs         <= blk_cs_t'(1) << w_blk_sel;
                        o_fetch_cmd  <= 1'b1;  // Reads and writes both fetch
                        r_tx_pending <= 1'b1;
                        r_state      <= DATA;
                     end
                  end
               end
               DATA: begin
                  if (w_sck_rise) begin
                     r_rx_shift <= w_rx_byte[6:0];
                     r_bit_cnt  <= r_bit_cnt + 3'd1;
                     if (r_bit_cnt == 3'd7) begin
                        o_data_in  <= w_rx_byte;
                        o_load_cmd <= r_cmd_write;
                        r_state    <= DONE;
                     end
                  end else if (w_sck_fall) begin
                     if (r_tx_pending) begin
                        r_tx_shift   <= i_data_out;     // Bit 7 out before 9th rise
                        r_tx_pending <= 1'b0;
                     end else begin
                        r_tx_shift <= {r_tx_shift[6:0], 1'b0};
                     end
                  end
               end
               DONE: r_state <= DONE;                   // Extra bytes ignored
               default: r_state <= IDLE;
            endcase
         end
      end
   end

   assign o_spi_miso = r_tx_shift[7];   // MSB first

endmodule

`default_nettype wire

// File: common/rf_ctrl_pkg.sv
`default_nettype none

package rf_ctrl_pkg;

   // RF path modes, codes 5..7 are invalid
   typedef enum logic [2:0] {
      RF_OFF   = 3'd0,
      RF_RX_09 = 3'd1,
      RF_RX_24 = 3'd2,
      RF_TX_09 = 3'd3,
      RF_TX_24 = 3'd4
   } rf_mode_t;

   // System block register codes
   localparam logic [4:0] SYS_IOC_VERSION = 5'd0;
   localparam logic [4:0] SYS_IOC_SCRATCH = 5'd1;
   localparam logic [4:0] SYS_IOC_STATUS  = 5'd2;

   // I/O block register codes
   localparam logic [4:0] IO_IOC_RF_MODE  = 5'd0;
   localparam logic [4:0] IO_IOC_DIG_OUT  = 5'd1;
   localparam logic [4:0] IO_IOC_DIG_IN   = 5'd2;

   // DIG_OUT bit positions
   localparam int DOUT_LED0     = 0;
   localparam int DOUT_LED1     = 1;
   localparam int DOUT_LDO_2V8  = 2;
   localparam int DOUT_MIXER_FM = 3;

   localparam logic [7:0] FW_VERSION = 8'h12;

endpackage

`default_nettype wire

// File: common/spi_proto_pkg.sv
`default_nettype none

package spi_proto_pkg;

   typedef logic [7:0] spi_byte_t;     // One byte on MOSI or MISO
   typedef logic [4:0] ioc_t;          // Register code inside a block
   typedef logic [1:0] blk_sel_t;      // Block number from the command byte
   typedef logic [3:0] blk_cs_t;       // One-hot block select

   // Block numbers, also the bit index in blk_cs_t
   localparam blk_sel_t BLK_SYS = 2'd0;
   localparam blk_sel_t BLK_IO  = 2'd1;
   localparam blk_sel_t BLK_SMI = 2'd2;
   localparam blk_sel_t BLK_RSV = 2'd3;

   // Command byte fields, MSB first on the wire
   localparam int CMD_WR_BIT  = 7;     // 1 = write
   localparam int CMD_BLK_MSB = 6;
   localparam int CMD_BLK_LSB = 5;
   localparam int CMD_IOC_MSB = 4;     // ioc occupies [4:0]

   localparam spi_byte_t BLK_RESERVED_DATA = 8'hA5;
   localparam int        SCK_SYNC_STAGES   = 2;

endpackage

`default_nettype wire
